//--- include/sensor_cfg.svh
// build constants for the ECG sensor core
// include in any file that needs command codes, the frame tag or the ADS init table
`ifndef SENSOR_CFG_SVH
`define SENSOR_CFG_SVH

// ====================
// host commands
// ====================
`define SENSOR_CMD_RUN      8'h52  // 'R', enter continuous read
`define SENSOR_CMD_STOP     8'h53  // 'S', leave continuous read

// tag in the top byte of every ECG frame
`define SENSOR_TAG_ADS      8'hAA

// ====================
// ADS1292 init table
// ====================
`define ADS_INIT_COUNT      11     // CONFIG1 .. GPIO
`define ADS_INIT_FIRST_ADDR 8'h01  // write i lands on first addr + i
// entry 0 in the low byte
// CONFIG1 01, CONFIG2 E0, LOFF 10, CH1SET 81, CH2SET 00, RLD_SENS 2C,
// LOFF_SENS 0E, LOFF_STAT 40, RESP1 02, RESP2 05, GPIO 00
`define ADS_INIT_DATA       88'h00_05_02_40_0E_2C_00_81_10_E0_01

// sample buffer
`define SAMPLE_FIFO_DEPTH   8      // power of two

`endif

//--- logic/sensor_pkg.sv
// shared types for the ECG sensor core
// modules pull these in with a wildcard import in their header
`default_nettype none

package sensor_pkg;

	typedef logic [7:0]  byte_t;       // reg addr, reg data or command code
	typedef logic [23:0] sample_t;     // one channel 2 sample
	typedef logic [31:0] frame_t;      // tag in [31:24], sample below
	typedef logic [15:0] host_word_t;  // command code in [15:8]

	// ADS1292 control bits
	typedef enum logic [2:0] {
		CMD_IDLE   = 3'd0,
		CMD_SYSCMD = 3'd1,
		CMD_WREG   = 3'd2,
		CMD_RREG   = 3'd3,
		CMD_RDATAC = 3'd4,
		CMD_SDATAC = 3'd5
	} ads_cmd_e;

	// top level sequencing
	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_START,
		CORE_STANDBY,
		CORE_READING
	} core_state_e;

	// front end command sequencing
	typedef enum logic [2:0] {
		ADS_IDLE,
		ADS_SETTING,
		ADS_WREG_PULSE,
		ADS_WREG_WAIT,
		ADS_RUN,
		ADS_STREAM,
		ADS_STOP
	} ads_state_e;

endpackage

`default_nettype wire

//--- logic/ads_ctrl_if.sv
// request and done levels between the core controller and the ADS sequencer
// a request is served while it differs from its done level
`timescale 1ns/1ps
`default_nettype none

interface ads_ctrl_if;

	logic init_req;   // level, from controller
	logic init_done;  // level, held until reset
	logic run_req;    // level, from controller
	logic run_done;   // level, high while in continuous read

	modport ctrl (
		output init_req,
		output run_req,
		input  init_done,
		input  run_done
	);

	modport seq (
		input  init_req,
		input  run_req,
		output init_done,
		output run_done
	);

endinterface

`default_nettype wire

//--- logic/sensor_ctrl.sv
// decodes host commands and steps the core through init, standby and reading
// drives the request levels toward the ADS sequencer
`timescale 1ns/1ps
`default_nettype none
`include "sensor_cfg.svh"

module sensor_ctrl import sensor_pkg::*; (
	input  logic       i_CLK,
	input  logic       i_RST,
	input  logic       i_rx_valid,
	input  host_word_t i_rx_data,
	ads_ctrl_if.ctrl   ads,
	output logic       o_chip_set,
	output logic       o_run_set,
	output logic       o_core_busy
);

	core_state_e r_state;
	logic        r_run_mode;  // last run/stop seen
	byte_t       w_cmd;

	assign w_cmd = i_rx_data[15:8];  // code sits in the high byte

	assign ads.init_req = (r_state == CORE_START);
	// run only once the chip is set up
	assign ads.run_req = r_run_mode &&
		((r_state == CORE_STANDBY) || (r_state == CORE_READING));

	// ====================
	// host command decode
	// ====================
	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_run_mode <= 1'b0;
		end else if (i_rx_valid) begin
			if (w_cmd == `SENSOR_CMD_RUN)
				r_run_mode <= 1'b1;
			else if (w_cmd == `SENSOR_CMD_STOP)
				r_run_mode <= 1'b0;
			// anything else dropped
		end
	end

	// ====================
	// core FSM and status
	// ====================
	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_state     <= CORE_IDLE;
			o_chip_set  <= 1'b0;
			o_run_set   <= 1'b0;
			o_core_busy <= 1'b0;
		end else begin
			o_chip_set <= ads.init_done;  // one cycle behind done
			o_run_set  <= ads.run_done;
			case (r_state)
			CORE_IDLE: begin
				r_state <= CORE_START;
			end
			CORE_START: begin
				if (ads.init_done) r_state <= CORE_STANDBY;  // table written
			end
			CORE_STANDBY: begin
				if (r_run_mode && ads.run_done) begin  // RDATAC went out
					r_state     <= CORE_READING;
					o_core_busy <= 1'b1;
				end
			end
			CORE_READING: begin
				if (!ads.run_done) begin  // SDATAC went out
					r_state     <= CORE_STANDBY;
					o_core_busy <= 1'b0;
				end
			end
			default: r_state <= CORE_IDLE;
			endcase
		end
	end

	// no streaming request may reach an unconfigured front end
	a_run_after_init: assert property (@(posedge i_CLK) disable iff (i_RST)
		$rose(ads.run_req) |-> ads.init_done);

endmodule

`default_nettype wire

//--- logic/ads_sequencer.sv
// drives the ADS1292 command port, writes the init table, enters and leaves RDATAC
// and pushes every channel 2 sample seen while streaming
`timescale 1ns/1ps
`default_nettype none
`include "sensor_cfg.svh"

module ads_sequencer import sensor_pkg::*; (
	input  logic     i_CLK,
	input  logic     i_RST,
	ads_ctrl_if.seq  ads,
	output ads_cmd_e o_ads_control,
	output byte_t    o_ads_reg_addr,
	output byte_t    o_ads_data_in,
	input  logic     i_ads_busy,
	input  logic     i_ads_data_ready,
	input  sample_t  i_ads_data,
	output logic     o_push,
	output sample_t  o_push_data
);

	localparam logic [8*`ADS_INIT_COUNT-1:0] init_table = `ADS_INIT_DATA;

	ads_state_e r_state;
	logic [3:0] r_wr_cnt;     // next init entry
	logic       r_init_done;
	logic       r_run_done;
	logic       w_wr_issue;   // WREG goes out this edge

	assign w_wr_issue   = (r_state == ADS_SETTING) && (r_wr_cnt != 4'(`ADS_INIT_COUNT));

	assign ads.init_done = r_init_done;
	assign ads.run_done  = r_run_done;

	// ====================
	// command FSM
	// ====================
	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_state       <= ADS_IDLE;
			r_wr_cnt      <= 4'd0;
			r_init_done   <= 1'b0;
			r_run_done    <= 1'b0;
			o_ads_control <= CMD_IDLE;
			o_push        <= 1'b0;
		end else begin
			o_ads_control <= CMD_IDLE;  // commands are single cycle
			o_push        <= 1'b0;
			case (r_state)
			ADS_IDLE: begin
				if (ads.init_req && !r_init_done) begin
					r_wr_cnt <= 4'd0;
					r_state  <= ADS_SETTING;
				end else if (ads.run_req && !r_run_done) begin
					o_ads_control <= CMD_RDATAC;
					r_run_done    <= 1'b1;  // same edge as the pulse
					r_state       <= ADS_RUN;
				end
			end
			ADS_SETTING: begin
				if (w_wr_issue) begin
					o_ads_control <= CMD_WREG;
					r_wr_cnt      <= r_wr_cnt + 4'd1;
					r_state       <= ADS_WREG_PULSE;
				end else begin
					r_init_done <= 1'b1;  // all eleven written
					r_state     <= ADS_IDLE;
				end
			end
			ADS_WREG_PULSE: begin
				r_state <= ADS_WREG_WAIT;  // busy not raised yet
			end
			ADS_WREG_WAIT: begin
				if (!i_ads_busy) r_state <= ADS_SETTING;
			end
			ADS_RUN: begin
				r_state <= ADS_STREAM;  // chip entering RDATAC
			end
			ADS_STREAM: begin
				if (!ads.run_req && r_run_done) begin
					o_ads_control <= CMD_SDATAC;
					r_run_done    <= 1'b0;
					r_state       <= ADS_STOP;
				end else if (i_ads_data_ready) begin
					o_push <= 1'b1;  // sample held in o_push_data
				end
			end
			ADS_STOP: begin
				r_state <= ADS_IDLE;
			end
			default: r_state <= ADS_IDLE;
			endcase
		end
	end

	// write payload and sample capture
	always_ff @(posedge i_CLK) begin
		if (w_wr_issue) begin
			o_ads_reg_addr <= `ADS_INIT_FIRST_ADDR + {4'b0000, r_wr_cnt};
			o_ads_data_in  <= init_table[{r_wr_cnt, 3'b000} +: 8];
		end
		if (i_ads_data_ready)
			o_push_data <= i_ads_data;
	end

	// each write gets its own busy window
	a_wreg_spaced: assert property (@(posedge i_CLK) disable iff (i_RST)
		(o_ads_control == CMD_WREG) |=> (o_ads_control != CMD_WREG));

endmodule

`default_nettype wire

//--- logic/sample_fifo.sv
// show-ahead sample buffer between the ADS sequencer and the UART framer
// pushes into a full buffer are lost and latch o_overflow until reset
`timescale 1ns/1ps
`default_nettype none
`include "sensor_cfg.svh"

module sample_fifo import sensor_pkg::*; #(
	parameter int DEPTH = `SAMPLE_FIFO_DEPTH
) (
	input  logic    i_CLK,
	input  logic    i_RST,
	input  logic    i_push,
	input  sample_t i_push_data,
	input  logic    i_pop,
	output logic    o_empty,
	output sample_t o_head,
	output logic    o_overflow
);

	localparam int AW = $clog2(DEPTH);

	sample_t       r_mem [DEPTH];
	logic [AW-1:0] r_wr_ptr;  // wraps on its own
	logic [AW-1:0] r_rd_ptr;
	logic [AW:0]   r_count;   // 0 .. DEPTH
	logic          w_full;
	logic          w_wr_en;
	logic          w_rd_en;

	if ((DEPTH & (DEPTH - 1)) != 0) begin : g_depth_chk
		$error("sample_fifo DEPTH must be a power of two");
	end

	assign w_full  = (r_count == (AW+1)'(DEPTH));
	assign o_empty = (r_count == '0);
	assign w_wr_en = i_push && !w_full;  // drop when full
	assign w_rd_en = i_pop && !o_empty;
	assign o_head  = r_mem[r_rd_ptr];    // show-ahead

	// pointers, occupancy, sticky overflow
	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_wr_ptr   <= '0;
			r_rd_ptr   <= '0;
			r_count    <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (w_wr_en) r_wr_ptr <= r_wr_ptr + AW'(1);
			if (w_rd_en) r_rd_ptr <= r_rd_ptr + AW'(1);
			r_count <= r_count + {{AW{1'b0}}, w_wr_en} - {{AW{1'b0}}, w_rd_en};
			if (i_push && w_full) o_overflow <= 1'b1;  // sample lost
		end
	end

	always_ff @(posedge i_CLK) begin
		if (w_wr_en) r_mem[r_wr_ptr] <= i_push_data;
	end

	// framer must only pop a valid head
	a_no_pop_empty: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_pop |-> !o_empty);

endmodule

`default_nettype wire

//--- logic/uart_framer.sv
// takes samples off the FIFO head and hands tagged 32-bit frames to the UART transmitter
// one frame per pop, never on back-to-back cycles
`timescale 1ns/1ps
`default_nettype none
`include "sensor_cfg.svh"

module uart_framer import sensor_pkg::*; (
	input  logic    i_CLK,
	input  logic    i_RST,
	input  logic    i_empty,
	input  sample_t i_head,
	output logic    o_pop,
	input  logic    i_tx_ready,
	output logic    o_tx_valid,
	output frame_t  o_tx_data
);

	logic w_fire;

	// pop still in flight means head has not advanced yet
	assign w_fire = !i_empty && i_tx_ready && !o_pop;

	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			o_tx_valid <= 1'b0;
			o_pop      <= 1'b0;
		end else begin
			o_tx_valid <= w_fire;  // one cycle pulse
			o_pop      <= w_fire;  // retire the head alongside
		end
	end

	// frame payload
	always_ff @(posedge i_CLK) begin
		if (w_fire) o_tx_data <= {`SENSOR_TAG_ADS, i_head};
	end

	// transmitter sees a gap between frames
	a_valid_gap: assert property (@(posedge i_CLK) disable iff (i_RST)
		o_tx_valid |=> !o_tx_valid);

endmodule

`default_nettype wire

//--- logic/sensor_core.sv
// top level of the ECG sensor core
// controller and sequencer feed samples through the FIFO to the UART framer
`timescale 1ns/1ps
`default_nettype none

module sensor_core import sensor_pkg::*; (
	input  logic       i_CLK,
	input  logic       i_RST,
	// UART side
	input  logic       i_uart_rx_valid,
	input  host_word_t i_uart_rx_data,
	input  logic       i_uart_tx_ready,
	output logic       o_uart_tx_valid,
	output frame_t     o_uart_tx_data,
	// ADS1292 command port
	output ads_cmd_e   o_ads_control,
	output byte_t      o_ads_reg_addr,
	output byte_t      o_ads_data_in,
	input  logic       i_ads_busy,
	input  logic       i_ads_data_ready,
	input  sample_t    i_ads_data,
	// status
	output logic       o_chip_set,
	output logic       o_run_set,
	output logic       o_core_busy,
	output logic       o_overflow
);

	logic    w_push;       // sequencer -> fifo
	sample_t w_push_data;
	logic    w_pop;        // framer -> fifo
	logic    w_empty;
	sample_t w_head;

	ads_ctrl_if u_ads_if ();

	// ====================
	// producer
	// ====================
	sensor_ctrl u_ctrl (
		.i_CLK       (i_CLK),
		.i_RST       (i_RST),
		.i_rx_valid  (i_uart_rx_valid),
		.i_rx_data   (i_uart_rx_data),
		.ads         (u_ads_if.ctrl),
		.o_chip_set  (o_chip_set),
		.o_run_set   (o_run_set),
		.o_core_busy (o_core_busy)
	);

	ads_sequencer u_seq (
		.i_CLK            (i_CLK),
		.i_RST            (i_RST),
		.ads              (u_ads_if.seq),
		.o_ads_control    (o_ads_control),
		.o_ads_reg_addr   (o_ads_reg_addr),
		.o_ads_data_in    (o_ads_data_in),
		.i_ads_busy       (i_ads_busy),
		.i_ads_data_ready (i_ads_data_ready),
		.i_ads_data       (i_ads_data),
		.o_push           (w_push),
		.o_push_data      (w_push_data)
	);

	// buffer, default depth
	sample_fifo u_fifo (
		.i_CLK       (i_CLK),
		.i_RST       (i_RST),
		.i_push      (w_push),
		.i_push_data (w_push_data),
		.i_pop       (w_pop),
		.o_empty     (w_empty),
		.o_head      (w_head),
		.o_overflow  (o_overflow)
	);

	// ====================
	// consumer
	// ====================
	uart_framer u_framer (
		.i_CLK      (i_CLK),
		.i_RST      (i_RST),
		.i_empty    (w_empty),
		.i_head     (w_head),
		.o_pop      (w_pop),
		.i_tx_ready (i_uart_tx_ready),
		.o_tx_valid (o_uart_tx_valid),
		.o_tx_data  (o_uart_tx_data)
	);

endmodule

`default_nettype wire

//--- verif/tb_sensor_core.sv
// testbench for the ECG sensor core
// models the ADS1292 busy line and both UART sides, checks by concurrent assertions
`timescale 1ns/1ps
`default_nettype none
`include "sensor_cfg.svh"

module tb_sensor_core import sensor_pkg::*; ();

	// init ~70 cycles, ~35 samples at up to 5 cycles each, drains and idles
	localparam int TIMEOUT_CYCLES = 5000;

	logic        i_CLK;
	logic        i_RST;
	logic        i_uart_rx_valid;
	host_word_t  i_uart_rx_data;
	logic        i_uart_tx_ready;
	logic        o_uart_tx_valid;
	frame_t      o_uart_tx_data;
	ads_cmd_e    o_ads_control;
	byte_t       o_ads_reg_addr;
	byte_t       o_ads_data_in;
	logic        i_ads_busy = 1'b0;
	logic        i_ads_data_ready;
	sample_t     i_ads_data;
	logic        o_chip_set;
	logic        o_run_set;
	logic        o_core_busy;
	logic        o_overflow;

	sample_t     exp_q[$];          // frames still owed, oldest first
	sample_t     exp_head;
	int          exp_cnt = 0;
	logic [31:0] seed = 32'hb951;
	logic [1:0]  busy_left = 2'd0;
	logic        drop_sent;         // the one sample meant to overflow
	int          n_err = 0;
	int          n_frames = 0;
	int          n_kept = 0;
	int          n_wreg = 0;
	int          n_rdatac = 0;
	int          n_sdatac = 0;
	int          n_run_cmd = 0;
	int          n_stop_cmd = 0;
	int          cycles = 0;

	sensor_core i_dut (.*);

	initial begin
		i_CLK = 1'b0;
		forever #10 i_CLK = ~i_CLK;  // 50 MHz
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// init write i goes to first addr + i with byte i of the table
	function automatic byte_t table_addr(input int i);
		return 8'(`ADS_INIT_FIRST_ADDR + i);
	endfunction

	function automatic byte_t table_byte(input int i);
		logic [8*`ADS_INIT_COUNT-1:0] t;
		t = `ADS_INIT_DATA;
		return t[8*i +: 8];
	endfunction

	function automatic void report_error(input string msg);
		$display("error @ %0t ns: %s", $time, msg);
		n_err++;
	endfunction

	function automatic void refresh_head();
		exp_cnt  = exp_q.size();
		exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
	endfunction

	// ====================
	// stimulus tasks
	// ====================
	task automatic send_cmd(input byte_t code);
		@(posedge i_CLK);
		i_uart_rx_valid <= 1'b1;
		i_uart_rx_data  <= {code, 8'h5a};  // low byte unused
		if (code == `SENSOR_CMD_RUN) n_run_cmd++;
		if (code == `SENSOR_CMD_STOP) n_stop_cmd++;
		@(posedge i_CLK);
		i_uart_rx_valid <= 1'b0;
	endtask

	task automatic send_sample(input logic keep);
		seed = xorshift(seed);
		@(posedge i_CLK);
		i_ads_data_ready <= 1'b1;
		i_ads_data       <= seed[23:0];
		if (keep) begin
			exp_q.push_back(seed[23:0]);
			n_kept++;
			refresh_head();
		end
		@(posedge i_CLK);
		i_ads_data_ready <= 1'b0;
		repeat (int'(seed[25:24])) @(posedge i_CLK);  // uneven spacing
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0) @(posedge i_CLK);
		repeat (4) @(posedge i_CLK);
	endtask

	// ADS busy for three cycles after each WREG
	always @(posedge i_CLK) begin
		if (o_ads_control == CMD_WREG) begin
			i_ads_busy <= 1'b1;
			busy_left  <= 2'd2;
		end else if (busy_left != 2'd0) begin
			busy_left <= busy_left - 2'd1;
		end else begin
			i_ads_busy <= 1'b0;
		end
	end

	// output monitor for pulse counts and frame retire
	always @(posedge i_CLK) begin
		if (o_ads_control == CMD_WREG) n_wreg <= n_wreg + 1;
		if (o_ads_control == CMD_RDATAC) n_rdatac <= n_rdatac + 1;
		if (o_ads_control == CMD_SDATAC) n_sdatac <= n_sdatac + 1;
		if (o_uart_tx_valid) begin
			n_frames <= n_frames + 1;
			if (exp_q.size() != 0) void'(exp_q.pop_front());
			refresh_head();
		end
	end

	// ====================
	// checks
	// ====================
	a_reset_quiet: assert property (@(posedge i_CLK) $fell(i_RST) |->
		(o_ads_control == CMD_IDLE && !o_uart_tx_valid && !o_chip_set &&
		 !o_run_set && !o_core_busy && !o_overflow))
		else report_error("outputs active right after reset");
	a_wreg_table: assert property (@(posedge i_CLK) disable iff (i_RST)
		(o_ads_control == CMD_WREG) |-> (n_wreg < `ADS_INIT_COUNT && !o_chip_set &&
		 o_ads_reg_addr == table_addr(n_wreg) && o_ads_data_in == table_byte(n_wreg)))
		else report_error("init write with wrong index, address or data");
	a_chip_set: assert property (@(posedge i_CLK) disable iff (i_RST)
		$rose(o_chip_set) |-> (n_wreg == `ADS_INIT_COUNT))
		else report_error("chip set before all init writes");
	a_chip_held: assert property (@(posedge i_CLK) disable iff (i_RST)
		o_chip_set |=> o_chip_set)
		else report_error("chip set dropped");
	a_ctl_legal: assert property (@(posedge i_CLK) disable iff (i_RST)
		o_ads_control inside {CMD_IDLE, CMD_WREG, CMD_RDATAC, CMD_SDATAC})
		else report_error("unexpected ADS control code");
	a_rdatac: assert property (@(posedge i_CLK) disable iff (i_RST)
		(o_ads_control == CMD_RDATAC) |-> (n_rdatac < n_run_cmd) ##1 (o_run_set && o_core_busy))
		else report_error("RDATAC without run command or status did not rise");
	a_sdatac: assert property (@(posedge i_CLK) disable iff (i_RST)
		(o_ads_control == CMD_SDATAC) |-> (n_sdatac < n_stop_cmd) ##1 (!o_run_set && !o_core_busy))
		else report_error("SDATAC without stop command or status did not fall");
	a_status_cause: assert property (@(posedge i_CLK) disable iff (i_RST)
		((o_run_set != $past(o_run_set)) || (o_core_busy != $past(o_core_busy))) |->
		($past(o_ads_control) == CMD_RDATAC || $past(o_ads_control) == CMD_SDATAC))
		else report_error("status changed without RDATAC or SDATAC");
	a_frame_match: assert property (@(posedge i_CLK) disable iff (i_RST)
		o_uart_tx_valid |-> (exp_cnt != 0 && o_uart_tx_data == {`SENSOR_TAG_ADS, exp_head}))
		else report_error("frame does not match the next expected sample");
	a_frame_gap: assert property (@(posedge i_CLK) disable iff (i_RST)
		o_uart_tx_valid |=> !o_uart_tx_valid)
		else report_error("frames on two cycles in a row");
	a_overflow_cause: assert property (@(posedge i_CLK) disable iff (i_RST)
		$rose(o_overflow) |-> drop_sent)
		else report_error("overflow set while FIFO had room");

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge i_CLK);
			cycles++;
		end
		$display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	// ====================
	// test sequence
	// ====================
	initial begin
		i_RST            = 1'b1;
		i_uart_rx_valid  = 1'b0;
		i_uart_rx_data   = '0;
		i_uart_tx_ready  = 1'b1;
		i_ads_data_ready = 1'b0;
		i_ads_data       = '0;
		drop_sent        = 1'b0;
		refresh_head();
		repeat (10) @(posedge i_CLK);
		i_RST <= 1'b0;

		while (!o_chip_set) @(posedge i_CLK);  // table written
		repeat (20) @(posedge i_CLK);
		send_cmd(8'h41);                       // unknown code, ignored
		repeat (10) @(posedge i_CLK);

		send_cmd(`SENSOR_CMD_RUN);
		while (!(o_run_set && o_core_busy)) @(posedge i_CLK);
		repeat (20) send_sample(1'b1);
		wait_drained();
		send_cmd(8'h41);                       // unknown code while streaming
		repeat (10) @(posedge i_CLK);

		// back-pressure fills the FIFO then one past full
		i_uart_tx_ready <= 1'b0;
		repeat (`SAMPLE_FIFO_DEPTH) send_sample(1'b1);
		drop_sent = 1'b1;
		send_sample(1'b0);
		repeat (4) @(posedge i_CLK);
		i_uart_tx_ready <= 1'b1;
		wait_drained();

		send_cmd(`SENSOR_CMD_STOP);
		while (o_run_set || o_core_busy) @(posedge i_CLK);
		repeat (4) send_sample(1'b0);          // no frames after SDATAC
		repeat (20) @(posedge i_CLK);

		assert (n_wreg == `ADS_INIT_COUNT) else report_error("wrong number of init writes");
		assert (n_rdatac == 1 && n_sdatac == 1) else report_error("wrong RDATAC/SDATAC count");
		assert (exp_q.size() == 0) else report_error("expected frames never came out");
		assert (n_frames == n_kept) else report_error("frame count differs from kept samples");
		assert (o_overflow) else report_error("overflow not set after dropped sample");
		$display("done: %0d errors, %0d frames, %0d wreg, %0d rdatac, %0d sdatac",
			n_err, n_frames, n_wreg, n_rdatac, n_sdatac);
		if (n_err == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
logic/sensor_pkg.sv
logic/ads_ctrl_if.sv
logic/sensor_ctrl.sv
logic/ads_sequencer.sv
logic/sample_fifo.sv
logic/uart_framer.sv
logic/sensor_core.sv
verif/tb_sensor_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sensor core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module tb_sensor_core -o tb_sensor_core

out=$(./obj_dir/tb_sensor_core)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1
